// File: branch_predictor.f
+incdir+verification
source/btac_pkg.sv
source/branch_target_buffer.sv
source/branch_history_table.sv
source/fetch_predict_stage.sv
source/resolve_update_stage.sv
source/branch_predictor.sv
verification/branch_predictor_tb.sv

// File: source/branch_history_table.sv
`timescale 1ns/100ps

module branch_history_table #(
  parameter int bht_depth = 64,
  localparam int bht_index_width = $clog2(bht_depth)
) (
  input  logic                       clock,
  input  logic                       reset,

  // Lookup port.
  input  logic [bht_index_width-1:0] read_index,
  output btac_pkg::counter_t         read_counter,

  // Training port.
  input  logic                       update_enable,
  input  logic [bht_index_width-1:0] update_index,
  input  logic                       update_taken
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counter array
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  btac_pkg::counter_t counter_array [bht_depth];
  btac_pkg::counter_t update_counter;
  btac_pkg::counter_t next_counter;

  assign update_counter = counter_array[update_index];

  // Saturating step of the addressed counter.
  always_comb begin
    next_counter = update_counter;
    if (update_taken) begin
      if (update_counter != btac_pkg::counter_strong_taken) begin
        next_counter = update_counter + 2'd1;
      end
    end else begin
      if (update_counter != btac_pkg::counter_strong_not) begin
        next_counter = update_counter - 2'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < bht_depth; i++) begin
        counter_array[i] <= btac_pkg::counter_weak_not;
      end
    end else if (update_enable) begin
      counter_array[update_index] <= next_counter;  // Read-modify-write.
    end
  end

  assign read_counter = counter_array[read_index];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Updated counter stays a valid encoding.
  counter_in_range: assert property (
    @(posedge clock) disable iff (!reset)
    update_enable |=> !$isunknown(counter_array[$past(update_index)])
  ) else $error("BHT counter left range after update");

endmodule

// File: source/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor #(
  parameter int btb_depth = 16,
  parameter int bht_depth = 64
) (
  input  logic               clock,
  input  logic               reset,

  // Fetch side.
  input  logic               fetch_valid,
  input  btac_pkg::address_t fetch_pc,
  input  logic               flush,
  output logic               pred_valid,
  output logic               pred_taken,
  output btac_pkg::address_t pred_target,

  // Execute side.
  input  logic               resolve_valid,
  input  btac_pkg::address_t resolve_pc,
  input  logic               resolve_taken,
  input  btac_pkg::address_t resolve_target,
  input  logic               resolve_pred_taken,
  input  btac_pkg::address_t resolve_pred_target,
  output logic               miss,
  output btac_pkg::address_t miss_addr
);

  localparam int btb_index_width = $clog2(btb_depth);
  localparam int bht_index_width = $clog2(bht_depth);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Array wiring
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [btb_index_width-1:0] btb_read_index;
  logic                       btb_valid;
  btac_pkg::address_t         btb_tag;
  btac_pkg::address_t         btb_target;
  logic                       btb_write_enable;
  logic [btb_index_width-1:0] btb_write_index;
  btac_pkg::address_t         btb_write_tag;
  btac_pkg::address_t         btb_write_target;

  logic [bht_index_width-1:0] bht_read_index;
  btac_pkg::counter_t         bht_counter;
  logic                       bht_update_enable;
  logic [bht_index_width-1:0] bht_update_index;
  logic                       bht_update_taken;

  fetch_predict_stage #(
    .btb_depth (btb_depth),
    .bht_depth (bht_depth)
  ) fetch_stage (
    .clock          (clock),
    .reset          (reset),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .flush          (flush),
    .btb_read_index (btb_read_index),
    .btb_valid      (btb_valid),
    .btb_tag        (btb_tag),
    .btb_target     (btb_target),
    .bht_read_index (bht_read_index),
    .bht_counter    (bht_counter),
    .pred_valid     (pred_valid),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target)
  );

  branch_target_buffer #(
    .btb_depth (btb_depth)
  ) btb (
    .clock        (clock),
    .reset        (reset),
    .read_index   (btb_read_index),
    .read_valid   (btb_valid),
    .read_tag     (btb_tag),
    .read_target  (btb_target),
    .write_enable (btb_write_enable),
    .write_index  (btb_write_index),
    .write_tag    (btb_write_tag),
    .write_target (btb_write_target)
  );

  branch_history_table #(
    .bht_depth (bht_depth)
  ) bht (
    .clock         (clock),
    .reset         (reset),
    .read_index    (bht_read_index),
    .read_counter  (bht_counter),
    .update_enable (bht_update_enable),
    .update_index  (bht_update_index),
    .update_taken  (bht_update_taken)
  );

  resolve_update_stage #(
    .btb_depth (btb_depth),
    .bht_depth (bht_depth)
  ) resolve_stage (
    .clock               (clock),
    .reset               (reset),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pred_target (resolve_pred_target),
    .miss                (miss),
    .miss_addr           (miss_addr),
    .btb_write_enable    (btb_write_enable),
    .btb_write_index     (btb_write_index),
    .btb_write_tag       (btb_write_tag),
    .btb_write_target    (btb_write_target),
    .bht_update_enable   (bht_update_enable),
    .bht_update_index    (bht_update_index),
    .bht_update_taken    (bht_update_taken)
  );

endmodule

// File: source/branch_target_buffer.sv
`timescale 1ns/100ps

module branch_target_buffer #(
  parameter int btb_depth = 16,
  localparam int btb_index_width = $clog2(btb_depth)
) (
  input  logic                       clock,
  input  logic                       reset,

  // Lookup port.
  input  logic [btb_index_width-1:0] read_index,
  output logic                       read_valid,
  output btac_pkg::address_t         read_tag,
  output btac_pkg::address_t         read_target,

  // Training port.
  input  logic                       write_enable,
  input  logic [btb_index_width-1:0] write_index,
  input  btac_pkg::address_t         write_tag,
  input  btac_pkg::address_t         write_target
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [btb_depth-1:0] valid_bits;
  btac_pkg::address_t   tag_array    [btb_depth];
  btac_pkg::address_t   target_array [btb_depth];

  // Reset clears the valid bits and a write sets one.
  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_bits <= '0;
    end else if (write_enable) begin
      valid_bits[write_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write_enable) begin
      tag_array[write_index]    <= write_tag;
      target_array[write_index] <= write_target;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Same-cycle read for the lookup stage.
  assign read_valid  = valid_bits[read_index];
  assign read_tag    = tag_array[read_index];
  assign read_target = target_array[read_index];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // An unknown strobe would corrupt the valid bits.
  write_enable_known: assert property (
    @(posedge clock) disable iff (!reset)
    !$isunknown(write_enable)
  ) else $error("BTB write_enable is unknown");

endmodule

// File: source/btac_pkg.sv
package btac_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Instruction address, also used as the BTB tag.
  typedef logic [31:0] address_t;

  // Two bit saturating prediction counter.
  typedef logic [1:0] counter_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counter encoding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Upper bit set means predict taken.
  localparam counter_t counter_strong_not   = 2'd0;
  localparam counter_t counter_weak_not     = 2'd1;  // Reset value.
  localparam counter_t counter_weak_taken   = 2'd2;
  localparam counter_t counter_strong_taken = 2'd3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Fall-through step between sequential instructions.
  localparam address_t instruction_bytes = 32'd4;

endpackage

// File: source/fetch_predict_stage.sv
`timescale 1ns/100ps

module fetch_predict_stage #(
  parameter int btb_depth = 16,
  parameter int bht_depth = 64,
  localparam int btb_index_width = $clog2(btb_depth),
  localparam int bht_index_width = $clog2(bht_depth)
) (
  input  logic                       clock,
  input  logic                       reset,

  // From fetch.
  input  logic                       fetch_valid,
  input  btac_pkg::address_t         fetch_pc,
  input  logic                       flush,

  // Target buffer lookup.
  output logic [btb_index_width-1:0] btb_read_index,
  input  logic                       btb_valid,
  input  btac_pkg::address_t         btb_tag,
  input  btac_pkg::address_t         btb_target,

  // History table lookup.
  output logic [bht_index_width-1:0] bht_read_index,
  input  btac_pkg::counter_t         bht_counter,

  // Prediction, one cycle after fetch_valid.
  output logic                       pred_valid,
  output logic                       pred_taken,
  output btac_pkg::address_t         pred_target
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic               btb_hit;
  logic               direction_taken;
  logic               lookup_taken;
  btac_pkg::address_t fall_through;
  btac_pkg::address_t lookup_target;

  // Word aligned indices.
  assign btb_read_index = fetch_pc[btb_index_width+1:2];
  assign bht_read_index = fetch_pc[bht_index_width+1:2];

  // Full pc as tag avoids aliasing.
  assign btb_hit         = btb_valid && (btb_tag == fetch_pc);
  assign direction_taken = bht_counter[1];

  // Taken needs a target, so no hit means not taken.
  assign lookup_taken  = btb_hit && direction_taken;
  assign fall_through  = fetch_pc + btac_pkg::instruction_bytes;
  assign lookup_target = lookup_taken ? btb_target : fall_through;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (!reset) begin
      pred_valid <= 1'b0;
    end else begin
      pred_valid <= fetch_valid && !flush;  // Flush drops this lookup.
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      pred_taken  <= lookup_taken;
      pred_target <= lookup_target;
    end
  end

endmodule

// File: source/resolve_update_stage.sv
`timescale 1ns/100ps

module resolve_update_stage #(
  parameter int btb_depth = 16,
  parameter int bht_depth = 64,
  localparam int btb_index_width = $clog2(btb_depth),
  localparam int bht_index_width = $clog2(bht_depth)
) (
  input  logic                       clock,
  input  logic                       reset,

  // Resolved branch from execute.
  input  logic                       resolve_valid,
  input  btac_pkg::address_t         resolve_pc,
  input  logic                       resolve_taken,
  input  btac_pkg::address_t         resolve_target,
  input  logic                       resolve_pred_taken,
  input  btac_pkg::address_t         resolve_pred_target,

  // Redirect to fetch.
  output logic                       miss,
  output btac_pkg::address_t         miss_addr,

  // Target buffer training.
  output logic                       btb_write_enable,
  output logic [btb_index_width-1:0] btb_write_index,
  output btac_pkg::address_t         btb_write_tag,
  output btac_pkg::address_t         btb_write_target,

  // History table training.
  output logic                       bht_update_enable,
  output logic [bht_index_width-1:0] bht_update_index,
  output logic                       bht_update_taken
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare against prediction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic               direction_wrong;
  logic               target_wrong;
  logic               mispredict;
  btac_pkg::address_t redirect_addr;

  assign direction_wrong = resolve_taken != resolve_pred_taken;
  // Right direction but stale target.
  assign target_wrong    = resolve_taken && resolve_pred_taken &&
                           (resolve_target != resolve_pred_target);
  assign mispredict      = direction_wrong || target_wrong;

  assign redirect_addr = resolve_taken ? resolve_target
                                       : resolve_pc + btac_pkg::instruction_bytes;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registered outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (!reset) begin
      miss              <= 1'b0;
      btb_write_enable  <= 1'b0;
      bht_update_enable <= 1'b0;
    end else begin
      miss              <= resolve_valid && mispredict;
      btb_write_enable  <= resolve_valid && resolve_taken;  // Only taken branches.
      bht_update_enable <= resolve_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (resolve_valid) begin
      miss_addr        <= redirect_addr;
      btb_write_index  <= resolve_pc[btb_index_width+1:2];
      btb_write_tag    <= resolve_pc;
      btb_write_target <= resolve_target;
      bht_update_index <= resolve_pc[bht_index_width+1:2];
      bht_update_taken <= resolve_taken;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Redirect belongs to the resolve of the previous cycle.
  miss_after_resolve: assert property (
    @(posedge clock) disable iff (!reset)
    miss |-> $past(resolve_valid)
  ) else $error("miss raised without a resolve one cycle earlier");

endmodule

// File: verification/branch_predictor_tests.svh
`ifndef BRANCH_PREDICTOR_TESTS_SVH
`define BRANCH_PREDICTOR_TESTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Drive and compare helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

logic               exp_pred_taken;
btac_pkg::address_t exp_pred_target;
logic               exp_miss;
btac_pkg::address_t exp_miss_addr;
btac_pkg::address_t pend_pc;
logic               pend_taken;
btac_pkg::address_t pend_target;
logic               last_taken;
btac_pkg::address_t last_target;
logic               last_miss;
btac_pkg::address_t last_miss_addr;
btac_pkg::address_t trained_pc;  // Reused by the tag check.

function automatic btac_pkg::address_t random_pc();
  btac_pkg::address_t pc;
  pc      = $urandom();
  pc[1:0] = 2'b00;
  return pc;
endfunction

// Fixed table index, random upper bits.
function automatic btac_pkg::address_t pc_in_slot(input int slot);
  btac_pkg::address_t pc;
  pc = random_pc();
  pc[bht_index_width+1:2] = bht_index_width'(slot);
  return pc;
endfunction

task automatic next_cycle();
  @(posedge clock);
  #1;
endtask

task automatic close_cycle();
  next_cycle();
  fetch_valid   = 1'b0;
  flush         = 1'b0;
  resolve_valid = 1'b0;
endtask

task automatic issue_fetch(input btac_pkg::address_t pc, input logic flush_in);
  fetch_valid     = 1'b1;
  fetch_pc        = pc;
  flush           = flush_in;
  exp_pred_taken  = predict_taken(pc);
  exp_pred_target = predict_target(pc);
endtask

task automatic issue_resolve(input btac_pkg::address_t pc, input logic taken,
                             input btac_pkg::address_t target, input logic ptaken,
                             input btac_pkg::address_t ptarget);
  resolve_valid       = 1'b1;
  resolve_pc          = pc;
  resolve_taken       = taken;
  resolve_target      = target;
  resolve_pred_taken  = ptaken;
  resolve_pred_target = ptarget;
  exp_miss      = (taken != ptaken) || (taken && ptaken && target != ptarget);
  exp_miss_addr = taken ? target : pc + 32'd4;
  pend_pc       = pc;
  pend_taken    = taken;
  pend_target   = target;
endtask

task automatic compare_prediction(input string name);
  check_value({name, " pred_valid"}, 1'b1, pred_valid);
  check_value({name, " pred_taken"}, exp_pred_taken, pred_taken);
  check_value({name, " pred_target"}, exp_pred_target, pred_target);
  last_taken  = pred_taken;
  last_target = pred_target;
endtask

task automatic compare_redirect(input string name);
  check_value({name, " miss"}, exp_miss, miss);
  check_value({name, " miss_addr"}, exp_miss_addr, miss_addr);
  last_miss      = miss;
  last_miss_addr = miss_addr;
  train_reference(pend_pc, pend_taken, pend_target);
endtask

task automatic lookup(input string name, input btac_pkg::address_t pc);
  issue_fetch(pc, 1'b0);
  close_cycle();
  compare_prediction(name);
endtask

// Returns two cycles after resolve_valid, when training is visible.
task automatic resolve_branch(input string name, input btac_pkg::address_t pc,
                              input logic taken, input btac_pkg::address_t target,
                              input logic ptaken, input btac_pkg::address_t ptarget);
  issue_resolve(pc, taken, target, ptaken, ptarget);
  close_cycle();
  compare_redirect(name);
  next_cycle();
  check_value({name, " miss pulse"}, 1'b0, miss);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic after_reset_defaults();
  btac_pkg::address_t pc;
  check_value("after reset pred_valid", 1'b0, pred_valid);
  check_value("after reset miss", 1'b0, miss);
  for (int i = 0; i < 8; i++) begin
    pc = random_pc();
    lookup("after reset", pc);
    check_value("after reset taken", 1'b0, last_taken);
    check_value("after reset target", pc + 32'd4, last_target);
    check_value("after reset miss", 1'b0, miss);
  end
endtask

task automatic single_taken_training();
  btac_pkg::address_t pc;
  btac_pkg::address_t target;
  pc     = pc_in_slot(1);
  target = random_pc();
  lookup("training", pc);
  resolve_branch("training", pc, 1'b1, target, last_taken, last_target);
  check_value("training miss", 1'b1, last_miss);
  check_value("training miss_addr", target, last_miss_addr);
  lookup("training", pc);
  check_value("training taken", 1'b1, last_taken);
  check_value("training target", target, last_target);
  // Weak taken drops to not taken after one not-taken resolve.
  resolve_branch("training", pc, 1'b0, target, last_taken, last_target);
  lookup("training", pc);
  check_value("training weak counter", 1'b0, last_taken);
  resolve_branch("training", pc, 1'b1, target, last_taken, last_target);  // Retrain.
  trained_pc = pc;
endtask

task automatic counter_hysteresis();
  btac_pkg::address_t pc;
  btac_pkg::address_t target;
  pc     = pc_in_slot(2);
  target = random_pc();
  for (int i = 0; i < 3; i++) begin
    lookup("hysteresis", pc);
    resolve_branch("hysteresis", pc, 1'b1, target, last_taken, last_target);
  end
  lookup("hysteresis", pc);
  resolve_branch("hysteresis", pc, 1'b0, target, last_taken, last_target);
  lookup("hysteresis", pc);
  check_value("hysteresis first not-taken", 1'b1, last_taken);
  resolve_branch("hysteresis", pc, 1'b0, target, last_taken, last_target);
  lookup("hysteresis", pc);
  check_value("hysteresis second not-taken", 1'b0, last_taken);
  check_value("hysteresis target", pc + 32'd4, last_target);
endtask

task automatic miss_rules();
  btac_pkg::address_t pc;
  btac_pkg::address_t first;
  btac_pkg::address_t second;
  pc     = pc_in_slot(3);
  first  = random_pc();
  second = first + 32'h40;
  resolve_branch("miss rules", pc, 1'b1, first, 1'b0, pc + 32'd4);
  lookup("miss rules", pc);
  resolve_branch("miss rules", pc, 1'b1, first, last_taken, last_target);
  check_value("miss rules correct", 1'b0, last_miss);
  lookup("miss rules", pc);
  resolve_branch("miss rules", pc, 1'b1, second, last_taken, last_target);
  check_value("miss rules wrong target", 1'b1, last_miss);
  check_value("miss rules new target", second, last_miss_addr);
  lookup("miss rules", pc);
  resolve_branch("miss rules", pc, 1'b0, second, last_taken, last_target);
  check_value("miss rules not taken", 1'b1, last_miss);
  check_value("miss rules fall through", pc + 32'd4, last_miss_addr);
endtask

task automatic tag_mismatch();
  btac_pkg::address_t pc;
  pc = trained_pc ^ 32'h0010_0000;  // Same index, other tag.
  lookup("tag check", pc);
  check_value("tag check taken", 1'b0, last_taken);
  check_value("tag check target", pc + 32'd4, last_target);
endtask

task automatic flush_and_overlap();
  btac_pkg::address_t pc;
  btac_pkg::address_t target;
  pc     = pc_in_slot(4);
  target = random_pc();
  issue_fetch(pc, 1'b1);
  close_cycle();
  check_value("flush pred_valid", 1'b0, pred_valid);
  // Fetch sees the old state while the resolve trains.
  issue_fetch(pc, 1'b0);
  issue_resolve(pc, 1'b1, target, 1'b0, pc + 32'd4);
  close_cycle();
  compare_prediction("overlap");
  compare_redirect("overlap");
  check_value("overlap taken", 1'b0, last_taken);
  check_value("overlap miss", 1'b1, last_miss);
  next_cycle();
  lookup("overlap", pc);
  check_value("overlap trained target", target, last_target);
endtask

`endif

// File: verification/branch_predictor_tb.sv
`timescale 1ns/100ps

module branch_predictor_tb;

  localparam int btb_depth       = 16;
  localparam int bht_depth       = 64;
  localparam int btb_index_width = $clog2(btb_depth);
  localparam int bht_index_width = $clog2(bht_depth);
  localparam int clock_period    = 4;
  localparam int test_cycles     = 70;  // All tests together, rounded up.
  localparam int timeout_ns      = test_cycles * clock_period + 100;

  logic               clock;
  logic               reset;
  logic               fetch_valid;
  btac_pkg::address_t fetch_pc;
  logic               flush;
  logic               pred_valid;
  logic               pred_taken;
  btac_pkg::address_t pred_target;
  logic               resolve_valid;
  btac_pkg::address_t resolve_pc;
  logic               resolve_taken;
  btac_pkg::address_t resolve_target;
  logic               resolve_pred_taken;
  btac_pkg::address_t resolve_pred_target;
  logic               miss;
  btac_pkg::address_t miss_addr;

  branch_predictor dut0 (
    .clock               (clock),
    .reset               (reset),
    .fetch_valid         (fetch_valid),
    .fetch_pc            (fetch_pc),
    .flush               (flush),
    .pred_valid          (pred_valid),
    .pred_taken          (pred_taken),
    .pred_target         (pred_target),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pred_target (resolve_pred_target),
    .miss                (miss),
    .miss_addr           (miss_addr)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns.", timeout_ns);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired.");
  end

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", test_name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic               model_valid   [btb_depth];
  btac_pkg::address_t model_tag     [btb_depth];
  btac_pkg::address_t model_target  [btb_depth];
  btac_pkg::counter_t model_counter [bht_depth];

  function automatic void clear_reference();
    for (int i = 0; i < btb_depth; i++) model_valid[i] = 1'b0;
    for (int i = 0; i < bht_depth; i++) model_counter[i] = btac_pkg::counter_weak_not;
  endfunction

  function automatic logic predict_taken(input btac_pkg::address_t pc);
    logic [btb_index_width-1:0] bi;
    logic [bht_index_width-1:0] hi;
    bi = pc[btb_index_width+1:2];
    hi = pc[bht_index_width+1:2];
    return model_valid[bi] && (model_tag[bi] == pc) && model_counter[hi][1];
  endfunction

  function automatic btac_pkg::address_t predict_target(input btac_pkg::address_t pc);
    if (predict_taken(pc)) return model_target[pc[btb_index_width+1:2]];
    return pc + 32'd4;  // Fall through.
  endfunction

  function automatic void train_reference(input btac_pkg::address_t pc, input logic taken,
                                          input btac_pkg::address_t target);
    logic [btb_index_width-1:0] bi;
    logic [bht_index_width-1:0] hi;
    bi = pc[btb_index_width+1:2];
    hi = pc[bht_index_width+1:2];
    if (taken && model_counter[hi] != btac_pkg::counter_strong_taken) begin
      model_counter[hi] = model_counter[hi] + 2'd1;
    end else if (!taken && model_counter[hi] != btac_pkg::counter_strong_not) begin
      model_counter[hi] = model_counter[hi] - 2'd1;
    end
    if (taken) begin
      model_valid[bi]  = 1'b1;
      model_tag[bi]    = pc;
      model_target[bi] = target;
    end
  endfunction

  `include "branch_predictor_tests.svh"

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    reset               = 1'b0;
    fetch_valid         = 1'b0;
    fetch_pc            = '0;
    flush               = 1'b0;
    resolve_valid       = 1'b0;
    resolve_pc          = '0;
    resolve_taken       = 1'b0;
    resolve_target      = '0;
    resolve_pred_taken  = 1'b0;
    resolve_pred_target = '0;
    void'($urandom(32'h7681));
    clear_reference();
    repeat (3) @(posedge clock);
    #1 reset = 1'b1;
    after_reset_defaults();
    single_taken_training();
    counter_hysteresis();
    miss_rules();
    tag_mismatch();
    flush_and_overlap();
    $display("STATUS: PASS");
    $finish;
  end

endmodule
